/* build.f */
verilog/dcache_pkg.sv
verilog/burst_counter.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/lru_store.sv
verilog/cache_fsm.sv
verilog/dcache_top.sv
tests/dcache_chk.sv
tests/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_dcache -o tb_dcache
./obj_dir/tb_dcache

/* tests/dcache_chk.sv */
module dcache_chk (
  input logic clk,
  input logic rst,
  input logic ok,
  input logic stall,
  input logic sen,
  input logic wen,
  input logic last_beat
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and CPU protocol
  ////////////////////////////////////////////////////////////////////////////

  wen_in_burst: assert property (@(posedge clk) disable iff (rst) wen |-> sen)
    else $error("wen high outside a bus burst");

  ok_single: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("ok held for two cycles");

  ok_no_stall: assert property (@(posedge clk) disable iff (rst) !(ok && stall))
    else $error("ok and stall high together");

  // Direction may only flip at the last beat of a burst
  wen_stable: assert property (@(posedge clk) disable iff (rst)
                               (sen && !last_beat) |=> (!sen || $stable(wen)))
    else $error("wen changed inside a burst");

endmodule

bind dcache_top dcache_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .ok        (ok),
  .stall     (stall),
  .sen       (sen),
  .wen       (wen),
  .last_beat (last_beat)
);

/* tests/tb_dcache.sv */
module tb_dcache;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] fill_key  = 32'h3c5a_9e17;
  localparam int          max_wait  = 500;  // Cycles, covers two slow bursts

  typedef struct packed {
    logic                 write;
    logic [31:0]          addr;
    dcache_pkg::byte_en_t wbyte;
    logic [31:0]          wdata;
    logic [31:0]          exp_ins;
    logic                 burst;
    logic [31:0]          wb_line;  // Zero when no write-back is due
  } row_t;

  logic                 clk;
  logic                 rst;
  logic [31:0]          insaddr;
  logic [31:0]          din;
  dcache_pkg::byte_en_t wbyte;
  logic                 req;
  logic                 wreq;
  logic [31:0]          ins;
  logic                 ok;
  logic                 stall;
  logic                 sen;
  logic                 wen;
  logic [31:0]          addr;
  logic [31:0]          wdata;
  logic                 data_ok;
  logic [31:0]          sdata;

  logic [31:0] bus_mem  [logic [31:0]];
  logic [31:0] cpu_view [logic [31:0]];  // Memory as the CPU should see it
  row_t        rows     [$];
  logic        burst_seen;
  logic [31:0] wb_line;
  int          wb_count;
  int          fill_count;

  dcache_top dut (
    .clk     (clk),
    .rst     (rst),
    .insaddr (insaddr),
    .din     (din),
    .wbyte   (wbyte),
    .req     (req),
    .wreq    (wreq),
    .ins     (ins),
    .ok      (ok),
    .stall   (stall),
    .sen     (sen),
    .wen     (wen),
    .addr    (addr),
    .wdata   (wdata),
    .data_ok (data_ok),
    .sdata   (sdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference memory and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return {2'b00, a[31:2]} ^ fill_key;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input dcache_pkg::byte_en_t be);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
        r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] a);
    return bus_mem.exists(a) ? bus_mem[a] : init_word(a);
  endfunction

  function automatic logic [31:0] shadow_read(input logic [31:0] a);
    return cpu_view.exists(a) ? cpu_view[a] : init_word(a);
  endfunction

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_burst(input logic [31:0] a, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch at %0d ns: burst for %h got %b expected %b", $time, a, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bus_word(input dcache_pkg::cache_addr_u got_addr,
                                input logic [31:0] got_data,
                                input dcache_pkg::cache_addr_u exp_addr,
                                input logic [31:0] exp_data);
    if (got_addr.raw !== exp_addr.raw || got_data !== exp_data)
    begin
      $display("mismatch at %0d ns: write-back tag %h set %0d data %h expected %h / %h",
               $time, got_addr.f.tag, got_addr.f.index, got_data, exp_addr.raw, exp_data);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int          gap;
    int          beat_n;
    logic [31:0] beat_addr;
    gap     = int'($urandom(32'h5d2c) % 4);
    beat_n  = 0;
    data_ok = 1'b0;
    sdata   = '0;
    forever
    begin
      @(negedge clk);
      data_ok = 1'b0;
      if (sen)
      begin
        burst_seen = 1'b1;
        if (gap > 0)
          gap--;
        else
        begin
          beat_addr = addr + 32'(4 * beat_n);
          if (wen)
          begin
            if (wb_line == '0)
            begin
              $display("unexpected write-back burst to %h at %0d ns", addr, $time);
              stop_run();
            end
            check_bus_word(addr, wdata, wb_line, shadow_read(wb_line + 32'(4 * beat_n)));
            bus_mem[beat_addr] = wdata;
            wb_count++;
          end
          else
          begin
            sdata = mem_read(beat_addr);
            fill_count++;
          end
          data_ok = 1'b1;
          beat_n  = (beat_n == 15) ? 0 : beat_n + 1;
          gap     = int'($urandom % 4);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input logic write, input logic [31:0] a,
                         input dcache_pkg::byte_en_t be, input logic [31:0] d,
                         input logic [31:0] exp, input logic burst, input logic [31:0] wb);
    row_t r;
    r.write   = write;
    r.addr    = a;
    r.wbyte   = be;
    r.wdata   = d;
    r.exp_ins = exp;
    r.burst   = burst;
    r.wb_line = wb;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Set 1: refill, hit, partial write
    add_row(0, 32'h0001_0054, 4'h0, '0, init_word(32'h0001_0054), 1, '0);
    add_row(0, 32'h0001_0064, 4'h0, '0, init_word(32'h0001_0064), 0, '0);
    add_row(1, 32'h0001_0054, 4'b0011, 32'hdead_beef, 32'hdead_beef, 0, '0);
    add_row(0, 32'h0001_0054, 4'h0, '0,
            merge_bytes(init_word(32'h0001_0054), 32'hdead_beef, 4'b0011), 0, '0);
    // Set 3: lines A to D fill the ways
    add_row(1, 32'h0000_04c8, 4'hf, 32'h1111_1111, 32'h1111_1111, 1, '0);
    add_row(1, 32'h0000_08dc, 4'b1100, 32'h2222_2222, 32'h2222_2222, 1, '0);
    add_row(1, 32'h0000_0cc0, 4'hf, 32'h3333_3333, 32'h3333_3333, 1, '0);
    add_row(1, 32'h0000_10c4, 4'hf, 32'h4444_4444, 32'h4444_4444, 1, '0);
    add_row(0, 32'h0000_04c8, 4'h0, '0, 32'h1111_1111, 0, '0);
    add_row(0, 32'h0000_14c0, 4'h0, '0, init_word(32'h0000_14c0), 1, 32'h0000_08c0);  // B out
    add_row(0, 32'h0000_04c8, 4'h0, '0, 32'h1111_1111, 0, '0);
    add_row(0, 32'h0000_08dc, 4'h0, '0,
            merge_bytes(init_word(32'h0000_08dc), 32'h2222_2222, 4'b1100), 1, 32'h0000_0cc0);
    // Set 7: write allocate
    add_row(1, 32'h0000_25cc, 4'b0101, 32'ha1b2_c3d4, 32'ha1b2_c3d4, 1, '0);
    add_row(0, 32'h0000_25cc, 4'h0, '0,
            merge_bytes(init_word(32'h0000_25cc), 32'ha1b2_c3d4, 4'b0101), 0, '0);
  endtask

  task automatic run_row(input row_t r);
    int cycles;
    burst_seen = 1'b0;
    wb_count   = 0;
    fill_count = 0;
    wb_line    = r.wb_line;
    insaddr    = r.addr;
    wreq       = r.write;
    wbyte      = r.wbyte;
    din        = r.wdata;
    req        = 1'b1;
    if (r.write)
      cpu_view[r.addr] = merge_bytes(shadow_read(r.addr), r.wdata, r.wbyte);
    @(negedge clk);
    req    = 1'b0;
    cycles = 1;
    while (!ok && cycles < max_wait)
    begin
      check_flag("stall while busy", stall, 1'b1);
      @(negedge clk);
      cycles++;
    end
    if (!ok)
    begin
      $display("no ok from the cache for %h within %0d cycles", r.addr, max_wait);
      stop_run();
    end
    check_word("ins", ins, r.exp_ins);
    check_burst(r.addr, burst_seen, r.burst);
    if (!r.burst)
      check_word("hit latency", 32'(cycles), 32'd1);
    check_word("refill beats", 32'(fill_count), r.burst ? 32'd16 : 32'd0);
    check_word("write-back beats", 32'(wb_count), (r.wb_line != '0) ? 32'd16 : 32'd0);
    @(negedge clk);  // Idle cycle between requests
  endtask

  initial
  begin
    rst        = 1'b1;
    req        = 1'b0;
    wreq       = 1'b0;
    insaddr    = '0;
    din        = '0;
    wbyte      = '0;
    wb_line    = '0;
    burst_seen = 1'b0;
    wb_count   = 0;
    fill_count = 0;
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("ok after reset", ok, 1'b0);
    check_flag("stall after reset", stall, 1'b0);
    check_flag("sen after reset", sen, 1'b0);
    check_flag("wen after reset", wen, 1'b0);
    foreach (rows[i])
      run_row(rows[i]);
    $display("Verification passed");
    $finish;
  end

endmodule

/* verilog/burst_counter.sv */
module burst_counter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  data_ok,
  output dcache_pkg::word_idx_t beat,
  output logic                  last_beat
);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      beat <= '0;
    else if (start)
      beat <= '0;
    else if (data_ok)
      beat <= beat + 1'b1;  // Wraps to zero after the last word
  end

  assign last_beat = data_ok && (beat == dcache_pkg::word_idx_t'(dcache_pkg::line_words - 1));

endmodule

/* verilog/cache_fsm.sv */
module cache_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  logic                   hit,
  input  logic                   victim_dirty,
  input  dcache_pkg::way_t       hit_way,
  input  dcache_pkg::way_t       victim_way,
  input  logic                   last_beat,
  input  logic                   data_ok,
  input  logic                   req_write,
  output dcache_pkg::store_ctl_t ctl,
  output logic                   burst_start,
  output logic                   sen,
  output logic                   wen,
  output logic                   ok,
  output logic                   stall,
  output logic                   bus_sel_victim
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    INSTALL
  } state_t;

  state_t           state;
  state_t           next_state;
  dcache_pkg::way_t victim_q;  // Held from LOOKUP to INSTALL

  ////////////////////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= IDLE;
      victim_q <= '0;
    end
    else
    begin
      state <= next_state;
      if (state == LOOKUP && !hit)
        victim_q <= victim_way;
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
        if (req)
          next_state = LOOKUP;
      LOOKUP:
      begin
        if (hit)
          next_state = IDLE;
        else if (victim_dirty)
          next_state = WRITEBACK;
        else
          next_state = REFILL;
      end
      WRITEBACK:
        if (last_beat)
          next_state = REFILL;
      REFILL:
        if (last_beat)
          next_state = INSTALL;
      INSTALL:
        next_state = LOOKUP;  // Replay, which now hits
      default:
        next_state = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Store commands and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ctl     = '0;
    ctl.way = victim_q;
    case (state)
      LOOKUP:
      begin
        if (hit)
        begin
          ctl.way       = hit_way;
          ctl.touch     = 1'b1;
          ctl.cpu_write = req_write;
        end
        else
          ctl.way = victim_way;  // Fresh choice, for the dirty check
      end
      REFILL:
        ctl.fill_write = data_ok;
      INSTALL:
      begin
        ctl.install = 1'b1;
        ctl.clean   = 1'b1;
      end
      default: ;
    endcase
  end

  // Counter restarts for the first burst and again for the refill
  assign burst_start    = (state == LOOKUP && !hit) || (state == WRITEBACK && last_beat);
  assign ok             = (state == LOOKUP) && hit;
  assign stall          = (state != IDLE) && !ok;
  assign sen            = (state == WRITEBACK) || (state == REFILL);
  assign wen            = (state == WRITEBACK);
  assign bus_sel_victim = (state == WRITEBACK);

endmodule

/* verilog/data_store.sv */
module data_store (
  input  logic                   clk,
  input  dcache_pkg::index_t     index,
  input  dcache_pkg::word_idx_t  cpu_word,
  input  dcache_pkg::word_idx_t  beat,
  input  logic [31:0]            wdata_cpu,
  input  dcache_pkg::byte_en_t   wbyte,
  input  logic [31:0]            sdata,
  input  dcache_pkg::store_ctl_t ctl,
  input  dcache_pkg::way_t       rd_way,
  output logic [31:0]            cpu_rdata,
  output logic [31:0]            bus_wdata
);

  logic [31:0] mem [dcache_pkg::num_ways][dcache_pkg::num_sets][dcache_pkg::line_words];

  ////////////////////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (ctl.fill_write)
      mem[ctl.way][index][beat] <= sdata;  // Refill beat
    if (ctl.cpu_write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (wbyte[b])
          mem[ctl.way][index][cpu_word][8*b +: 8] <= wdata_cpu[8*b +: 8];
      end
    end
  end

  // CPU port follows the hit way
  assign cpu_rdata = mem[rd_way][index][cpu_word];

  // Write-back port walks the victim line beat by beat
  assign bus_wdata = mem[ctl.way][index][beat];

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int num_ways   = 4;
  localparam int way_bits   = 2;
  localparam int num_sets   = 16;  // Kept small for simulation
  localparam int index_bits = 4;
  localparam int line_words = 16;
  localparam int word_bits  = 4;
  localparam int tag_bits   = 22;

  typedef logic [way_bits-1:0]   way_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [word_bits-1:0]  word_idx_t;
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [1:0]            age_t;
  typedef logic [3:0]            byte_en_t;  // One bit per byte lane

  // CPU address, seen as a bus word or as cache fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      tag_t       tag;
      index_t     index;
      word_idx_t  word;
      logic [1:0] byte_off;
    } f;
  } cache_addr_u;

  typedef struct packed {
    cache_addr_u addr;
    logic        write;
    byte_en_t    wbyte;
    logic [31:0] wdata;
  } cpu_req_t;

  // Per-cycle commands from the FSM to the stores
  typedef struct packed {
    logic cpu_write;
    logic fill_write;
    logic install;
    logic touch;
    logic clean;
    way_t way;
  } store_ctl_t;

endpackage

/* verilog/dcache_top.sv */
module dcache_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          insaddr,
  input  logic [31:0]          din,
  input  dcache_pkg::byte_en_t wbyte,
  input  logic                 req,
  input  logic                 wreq,
  output logic [31:0]          ins,
  output logic                 ok,
  output logic                 stall,
  output logic                 sen,
  output logic                 wen,
  output logic [31:0]          addr,
  output logic [31:0]          wdata,
  input  logic                 data_ok,
  input  logic [31:0]          sdata
);

  dcache_pkg::cpu_req_t              req_q;
  dcache_pkg::store_ctl_t            ctl;
  dcache_pkg::way_t                  hit_way;
  dcache_pkg::way_t                  victim_way;
  dcache_pkg::word_idx_t             beat;
  dcache_pkg::tag_t                  victim_tag;
  dcache_pkg::cache_addr_u           bus_addr;
  logic [dcache_pkg::num_ways-1:0]   valid_mask;
  logic [31:0]                       cpu_rdata;
  logic                              hit;
  logic                              victim_dirty;
  logic                              last_beat;
  logic                              burst_start;
  logic                              bus_sel_victim;

  // Request capture
  always_ff @(posedge clk)
  begin
    if (req)
    begin
      req_q.addr.raw <= insaddr;
      req_q.write    <= wreq;
      req_q.wbyte    <= wbyte;
      req_q.wdata    <= din;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus address and CPU return
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    bus_addr = req_q.addr;
    if (bus_sel_victim)
      bus_addr.f.tag = victim_tag;  // Write-back goes to the victim's line
    bus_addr.f.word     = '0;
    bus_addr.f.byte_off = '0;
  end

  assign addr = bus_addr.raw;
  assign ins  = req_q.write ? req_q.wdata : cpu_rdata;

  cache_fsm u_fsm (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .hit_way        (hit_way),
    .victim_way     (victim_way),
    .last_beat      (last_beat),
    .data_ok        (data_ok),
    .req_write      (req_q.write),
    .ctl            (ctl),
    .burst_start    (burst_start),
    .sen            (sen),
    .wen            (wen),
    .ok             (ok),
    .stall          (stall),
    .bus_sel_victim (bus_sel_victim)
  );

  burst_counter u_beats (
    .clk       (clk),
    .rst       (rst),
    .start     (burst_start),
    .data_ok   (data_ok && sen),  // Beats only count inside a burst
    .beat      (beat),
    .last_beat (last_beat)
  );

  tag_store u_tags (
    .clk          (clk),
    .rst          (rst),
    .lookup       (req_q.addr),
    .fill_tag     (req_q.addr.f.tag),
    .ctl          (ctl),
    .hit          (hit),
    .hit_way      (hit_way),
    .valid_mask   (valid_mask),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  data_store u_data (
    .clk       (clk),
    .index     (req_q.addr.f.index),
    .cpu_word  (req_q.addr.f.word),
    .beat      (beat),
    .wdata_cpu (req_q.wdata),
    .wbyte     (req_q.wbyte),
    .sdata     (sdata),
    .ctl       (ctl),
    .rd_way    (hit_way),
    .cpu_rdata (cpu_rdata),
    .bus_wdata (wdata)
  );

  lru_store u_lru (
    .clk        (clk),
    .rst        (rst),
    .index      (req_q.addr.f.index),
    .valid_mask (valid_mask),
    .ctl        (ctl),
    .victim_way (victim_way)
  );

endmodule

/* verilog/lru_store.sv */
module lru_store (
  input  logic                            clk,
  input  logic                            rst,
  input  dcache_pkg::index_t              index,
  input  logic [dcache_pkg::num_ways-1:0] valid_mask,
  input  dcache_pkg::store_ctl_t          ctl,
  output dcache_pkg::way_t                victim_way
);

  dcache_pkg::age_t age [dcache_pkg::num_ways][dcache_pkg::num_sets];
  dcache_pkg::age_t old_age;
  dcache_pkg::age_t oldest;

  assign old_age = age[ctl.way][index];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < dcache_pkg::num_ways; w++)
        for (int s = 0; s < dcache_pkg::num_sets; s++)
          age[w][s] <= '0;
    end
    else if (ctl.touch)
    begin
      for (int w = 0; w < dcache_pkg::num_ways; w++)
      begin
        if (dcache_pkg::way_t'(w) == ctl.way)
          age[w][index] <= '0;
        else if (age[w][index] <= old_age && age[w][index] != 2'd3)
          age[w][index] <= age[w][index] + 2'd1;  // Saturates at 3
      end
    end
  end

  // Invalid way first, else the oldest, low way wins ties
  always_comb
  begin
    victim_way = '0;
    oldest     = age[0][index];
    for (int w = 1; w < dcache_pkg::num_ways; w++)
    begin
      if (age[w][index] > oldest)
      begin
        oldest     = age[w][index];
        victim_way = dcache_pkg::way_t'(w);
      end
    end
    for (int w = dcache_pkg::num_ways - 1; w >= 0; w--)
    begin
      if (!valid_mask[w])
        victim_way = dcache_pkg::way_t'(w);
    end
  end

endmodule

/* verilog/tag_store.sv */
module tag_store (
  input  logic                              clk,
  input  logic                              rst,
  input  dcache_pkg::cache_addr_u           lookup,
  input  dcache_pkg::tag_t                  fill_tag,
  input  dcache_pkg::store_ctl_t            ctl,
  output logic                              hit,
  output dcache_pkg::way_t                  hit_way,
  output logic [dcache_pkg::num_ways-1:0]   valid_mask,
  output logic                              victim_dirty,
  output dcache_pkg::tag_t                  victim_tag
);

  dcache_pkg::tag_t              tags  [dcache_pkg::num_ways][dcache_pkg::num_sets];
  logic [dcache_pkg::num_sets-1:0] valid [dcache_pkg::num_ways];
  logic [dcache_pkg::num_sets-1:0] dirty [dcache_pkg::num_ways];
  logic [dcache_pkg::num_ways-1:0] match;

  always_ff @(posedge clk)
  begin
    if (ctl.install)
      tags[ctl.way][lookup.f.index] <= fill_tag;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < dcache_pkg::num_ways; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
    end
    else
    begin
      if (ctl.install)
        valid[ctl.way][lookup.f.index] <= 1'b1;
      if (ctl.cpu_write)
        dirty[ctl.way][lookup.f.index] <= 1'b1;
      else if (ctl.clean)
        dirty[ctl.way][lookup.f.index] <= 1'b0;  // Fresh line matches memory
    end
  end

  // All ways compared at once, lowest matching way reported
  always_comb
  begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = dcache_pkg::num_ways - 1; w >= 0; w--)
    begin
      valid_mask[w] = valid[w][lookup.f.index];
      match[w]      = valid_mask[w] && (tags[w][lookup.f.index] == lookup.f.tag);
      if (match[w])
      begin
        hit     = 1'b1;
        hit_way = dcache_pkg::way_t'(w);
      end
    end
  end

  assign victim_dirty = valid[ctl.way][lookup.f.index] && dirty[ctl.way][lookup.f.index];
  assign victim_tag   = tags[ctl.way][lookup.f.index];

endmodule
